// ==== dspPkg.sv ====
`default_nettype none

package dspPkg;

	// register file size, fixed by the instruction format.
	localparam int regCount = 8;
	localparam int regAddrWidth = $clog2(regCount);

	localparam int immWidth = 8; // zero-extended by opLoad.

	typedef enum logic [2:0] {
		opAdd  = 3'd0, // a + b.
		opSub  = 3'd1, // a - b.
		opMac  = 3'd2, // a * b + c.
		opLoad = 3'd3, // immediate.
		opRead = 3'd4  // reports a, no write.
	} opcodeT;

	// one instruction as it crosses the handshake.
	typedef struct packed {
		opcodeT                  opcode;
		logic [regAddrWidth-1:0] dest;
		logic [regAddrWidth-1:0] srcA;
		logic [regAddrWidth-1:0] srcB;
		logic [regAddrWidth-1:0] srcC;
		logic [immWidth-1:0]     imm;
	} instrT;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            wrEn,
	input  logic [dspPkg::regAddrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0]            wrData,
	input  logic [dspPkg::regAddrWidth-1:0] srcA,
	input  logic [dspPkg::regAddrWidth-1:0] srcB,
	input  logic [dspPkg::regAddrWidth-1:0] srcC,
	output logic [dataWidth-1:0]            rdA,
	output logic [dataWidth-1:0]            rdB,
	output logic [dataWidth-1:0]            rdC
);

	// every register starts at zero.
	logic [dataWidth-1:0] mem [dspPkg::regCount] = '{default: '0};

	// three independent read ports, no read latency.
	assign rdA = mem[srcA];
	assign rdB = mem[srcB];
	assign rdC = mem[srcC];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData; // visible to readers after this edge.
		end
	end

endmodule

`default_nettype wire

// ==== instrCapture.sv ====
`default_nettype none

module instrCapture (
	input  logic          clk,
	input  logic          rstN,
	input  logic          req,
	input  dspPkg::instrT instr,
	output logic          ack,
	output logic          issueValid,
	output dspPkg::instrT issueInstr
);

	typedef enum logic {
		waitReq,    // ack low, watching for req.
		waitRelease // ack high until req drops.
	} stateT;

	stateT state;
	stateT nextState;
	logic  accept;

	// a new transfer is taken only while ack is low.
	assign accept = (state == waitReq) && req;

	always_comb begin
		nextState = state;
		case (state)
			waitReq: begin
				if (req) begin
					nextState = waitRelease;
				end
			end
			waitRelease: begin
				if (!req) begin
					nextState = waitReq; // ack falls with this edge.
				end
			end
			default: begin
				nextState = waitReq;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state      <= waitReq;
			issueValid <= 1'b0;
		end else begin
			state      <= nextState;
			issueValid <= accept; // one pulse per transfer.
		end
	end

	// instr is stable while req is high, so one sample is enough.
	always_ff @(posedge clk) begin
		if (accept) begin
			issueInstr <= instr;
		end
	end

	assign ack = (state == waitRelease);

endmodule

`default_nettype wire

// ==== operandFetch.sv ====
`default_nettype none

module operandFetch #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            issueValid,
	input  dspPkg::instrT                   issueInstr,
	output logic [dspPkg::regAddrWidth-1:0] srcA,
	output logic [dspPkg::regAddrWidth-1:0] srcB,
	output logic [dspPkg::regAddrWidth-1:0] srcC,
	input  logic [dataWidth-1:0]            rdA,
	input  logic [dataWidth-1:0]            rdB,
	input  logic [dataWidth-1:0]            rdC,
	input  logic                            bypassEn,
	input  logic [dspPkg::regAddrWidth-1:0] bypassAddr,
	input  logic [dataWidth-1:0]            bypassData,
	output logic                            fetchValid,
	output dspPkg::instrT                   fetchInstr,
	output logic [dataWidth-1:0]            opA,
	output logic [dataWidth-1:0]            opB,
	output logic [dataWidth-1:0]            opC
);

	logic [dataWidth-1:0] selA;
	logic [dataWidth-1:0] selB;
	logic [dataWidth-1:0] selC;

	// the word being written this cycle wins over the stale array value.
	function automatic logic [dataWidth-1:0] pickOperand(
		input logic [dspPkg::regAddrWidth-1:0] idx,
		input logic [dataWidth-1:0]            rd,
		input logic                            en,
		input logic [dspPkg::regAddrWidth-1:0] addr,
		input logic [dataWidth-1:0]            data
	);
		if (en && (idx == addr)) begin
			return data;
		end
		return rd;
	endfunction

	assign srcA = issueInstr.srcA;
	assign srcB = issueInstr.srcB;
	assign srcC = issueInstr.srcC;

	assign selA = pickOperand(issueInstr.srcA, rdA, bypassEn, bypassAddr, bypassData);
	assign selB = pickOperand(issueInstr.srcB, rdB, bypassEn, bypassAddr, bypassData);
	assign selC = pickOperand(issueInstr.srcC, rdC, bypassEn, bypassAddr, bypassData);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= issueValid;
		end
	end

	// operands travel with their instruction.
	always_ff @(posedge clk) begin
		if (issueValid) begin
			fetchInstr <= issueInstr;
			opA        <= selA;
			opB        <= selB;
			opC        <= selC;
		end
	end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none

module executeStage #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            fetchValid,
	input  dspPkg::instrT                   fetchInstr,
	input  logic [dataWidth-1:0]            opA,
	input  logic [dataWidth-1:0]            opB,
	input  logic [dataWidth-1:0]            opC,
	output logic                            resValid,
	output logic [dspPkg::regAddrWidth-1:0] resDest,
	output logic [dataWidth-1:0]            resData,
	output logic                            wrEn
);

	logic [dataWidth-1:0] result;
	logic                 writes;

	// all results wrap at dataWidth bits.
	always_comb begin
		case (fetchInstr.opcode)
			dspPkg::opAdd: begin
				result = opA + opB;
			end
			dspPkg::opSub: begin
				result = opA - opB;
			end
			dspPkg::opMac: begin
				result = opA * opB + opC; // product truncated before the add.
			end
			dspPkg::opLoad: begin
				result = dataWidth'(fetchInstr.imm);
			end
			dspPkg::opRead: begin
				result = opA;
			end
			default: begin
				result = opA;
			end
		endcase
	end

	assign writes = (fetchInstr.opcode != dspPkg::opRead);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resValid <= 1'b0;
			wrEn     <= 1'b0;
		end else begin
			resValid <= fetchValid;
			wrEn     <= fetchValid && writes; // read reports only.
		end
	end

	always_ff @(posedge clk) begin
		if (fetchValid) begin
			resDest <= fetchInstr.dest;
			resData <= result;
		end
	end

endmodule

`default_nettype wire

// ==== macPipe.sv ====
`default_nettype none

module macPipe #(
	parameter int dataWidth = 16
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            req,
	input  dspPkg::instrT                   instr,
	output logic                            ack,
	output logic                            resValid,
	output logic [dspPkg::regAddrWidth-1:0] resDest,
	output logic [dataWidth-1:0]            resData
);

	logic                            issueValid;
	dspPkg::instrT                   issueInstr;
	logic [dspPkg::regAddrWidth-1:0] srcA;
	logic [dspPkg::regAddrWidth-1:0] srcB;
	logic [dspPkg::regAddrWidth-1:0] srcC;
	logic [dataWidth-1:0]            rdA;
	logic [dataWidth-1:0]            rdB;
	logic [dataWidth-1:0]            rdC;
	logic                            fetchValid;
	dspPkg::instrT                   fetchInstr;
	logic [dataWidth-1:0]            opA;
	logic [dataWidth-1:0]            opB;
	logic [dataWidth-1:0]            opC;
	logic                            wrEn;

	instrCapture capture (
		.clk        (clk),
		.rstN       (rstN),
		.req        (req),
		.instr      (instr),
		.ack        (ack),
		.issueValid (issueValid),
		.issueInstr (issueInstr)
	);

	// the execute result doubles as write data and bypass source.
	operandFetch #(
		.dataWidth (dataWidth)
	) fetch (
		.clk        (clk),
		.rstN       (rstN),
		.issueValid (issueValid),
		.issueInstr (issueInstr),
		.srcA       (srcA),
		.srcB       (srcB),
		.srcC       (srcC),
		.rdA        (rdA),
		.rdB        (rdB),
		.rdC        (rdC),
		.bypassEn   (wrEn),
		.bypassAddr (resDest),
		.bypassData (resData),
		.fetchValid (fetchValid),
		.fetchInstr (fetchInstr),
		.opA        (opA),
		.opB        (opB),
		.opC        (opC)
	);

	executeStage #(
		.dataWidth (dataWidth)
	) execute (
		.clk        (clk),
		.rstN       (rstN),
		.fetchValid (fetchValid),
		.fetchInstr (fetchInstr),
		.opA        (opA),
		.opB        (opB),
		.opC        (opC),
		.resValid   (resValid),
		.resDest    (resDest),
		.resData    (resData),
		.wrEn       (wrEn)
	);

	regFile #(
		.dataWidth (dataWidth)
	) regs (
		.clk    (clk),
		.wrEn   (wrEn),
		.wrAddr (resDest),
		.wrData (resData),
		.srcA   (srcA),
		.srcB   (srcB),
		.srcC   (srcC),
		.rdA    (rdA),
		.rdB    (rdB),
		.rdC    (rdC)
	);

endmodule

`default_nettype wire

// ==== macPipe_properties.sv ====
`default_nettype none

module macPipe_properties (
	input logic clk,
	input logic rstN,
	input logic req,
	input logic ack,
	input logic resValid
);

	timeunit 1ns;
	timeprecision 1ps;

	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// a result pulse is a single cycle.
	resultPulse: assert property (@(posedge clk) disable iff (!rstN)
		resValid |=> !resValid)
		else $error("resValid held for two cycles");

	ackAfterReset: assert property (@(posedge clk)
		$rose(rstN) |-> !ack)
		else $error("ack high right after reset");

	resultLatency: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> ##2 resValid)
		else $error("no result two cycles after ack rose");

endmodule

`default_nettype wire

// ==== macPipe_tb.sv ====
`default_nettype none

module macPipe_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int dataWidth = 16;
	localparam int instrTotal = 314; // 8 + 16 + 200 + 40 + 50.
	localparam int cycleLimit = 40 * instrTotal + 100;

	logic                            clk = 1'b0;
	logic                            rstN;
	logic                            req;
	dspPkg::instrT                   instr;
	logic                            ack;
	logic                            resValid;
	logic [dspPkg::regAddrWidth-1:0] resDest;
	logic [dataWidth-1:0]            resData;

	// reference register contents, updated in issue order.
	logic [dataWidth-1:0]            model [dspPkg::regCount];
	logic [dspPkg::regAddrWidth-1:0] expDest [$];
	logic [dataWidth-1:0]            expData [$];

	int unsigned lcgState = 57964;
	int          errorCount = 0; // result mismatches.
	int          checkErrors = 0; // handshake count mismatches.
	int          pulseCount = 0;
	int          transferCount = 0;
	int          issuedCount = 0;
	int          cycleCount = 0;
	int          testCount = 0;

	macPipe #(
		.dataWidth (dataWidth)
	) uut (
		.clk      (clk),
		.rstN     (rstN),
		.req      (req),
		.instr    (instr),
		.ack      (ack),
		.resValid (resValid),
		.resDest  (resDest),
		.resData  (resData)
	);

	bind macPipe macPipe_properties props (
		.clk      (clk),
		.rstN     (rstN),
		.req      (req),
		.ack      (ack),
		.resValid (resValid)
	);

	always #10 clk = ~clk;

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [dspPkg::regAddrWidth-1:0] randReg();
		int unsigned r;
		r = lcgNext();
		return r[24 +: dspPkg::regAddrWidth];
	endfunction

	function automatic logic [dspPkg::immWidth-1:0] randByte();
		int unsigned r;
		r = lcgNext();
		return r[16 +: dspPkg::immWidth];
	endfunction

	function automatic int unsigned randGap();
		int unsigned r;
		r = lcgNext();
		return {29'd0, r[20:18]}; // 0 to 7 idle cycles.
	endfunction

	function automatic dspPkg::opcodeT randArith();
		int unsigned r;
		r = lcgNext();
		case (r[17:16])
			2'd0: return dspPkg::opAdd;
			2'd1: return dspPkg::opSub;
			default: return dspPkg::opMac;
		endcase
	endfunction

	function automatic dspPkg::opcodeT randAny();
		int unsigned r;
		r = lcgNext();
		case (r[18:16])
			3'd0: return dspPkg::opAdd;
			3'd1: return dspPkg::opSub;
			3'd2: return dspPkg::opMac;
			3'd3: return dspPkg::opLoad;
			default: return dspPkg::opRead;
		endcase
	endfunction

	function automatic dspPkg::instrT makeInstr(
		input dspPkg::opcodeT                  op,
		input logic [dspPkg::regAddrWidth-1:0] dest,
		input logic [dspPkg::regAddrWidth-1:0] a,
		input logic [dspPkg::regAddrWidth-1:0] b,
		input logic [dspPkg::regAddrWidth-1:0] c,
		input logic [dspPkg::immWidth-1:0]     imm
	);
		dspPkg::instrT ins;
		ins.opcode = op;
		ins.dest   = dest;
		ins.srcA   = a;
		ins.srcB   = b;
		ins.srcC   = c;
		ins.imm    = imm;
		return ins;
	endfunction

	// opcode rules, every result wrapped to dataWidth bits.
	function automatic logic [dataWidth-1:0] expectedResult(input dspPkg::instrT ins);
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] c;
		logic [dataWidth-1:0] r;
		a = model[ins.srcA];
		b = model[ins.srcB];
		c = model[ins.srcC];
		case (ins.opcode)
			dspPkg::opAdd: r = a + b;
			dspPkg::opSub: r = a - b;
			dspPkg::opMac: r = a * b + c;
			dspPkg::opLoad: r = {{(dataWidth - dspPkg::immWidth){1'b0}}, ins.imm};
			default: r = a;
		endcase
		return r;
	endfunction

	// four-phase source side, called on a rising edge.
	task automatic sendInstr(input dspPkg::instrT ins);
		logic [dataWidth-1:0] value;
		value = expectedResult(ins);
		if (ins.opcode != dspPkg::opRead) begin
			model[ins.dest] = value;
		end
		expDest.push_back(ins.dest);
		expData.push_back(value);
		while (ack) begin
			@(posedge clk); // previous transfer still closing.
		end
		instr <= ins;
		req   <= 1'b1;
		issuedCount++;
		@(posedge clk);
		while (!ack) begin
			@(posedge clk);
		end
		req <= 1'b0;
		transferCount++;
	endtask

	task automatic waitDrain();
		while (expData.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
	endtask

	task automatic finishTest(input string name, input int errBase, input int issBase);
		waitDrain();
		testCount++;
		$display("test %0d %s: %0d instructions, %0d errors", testCount, name,
			issuedCount - issBase, errorCount + checkErrors - errBase);
	endtask

	// results come back in issue order.
	always @(posedge clk) begin
		logic [dspPkg::regAddrWidth-1:0] wantDest;
		logic [dataWidth-1:0]            wantData;
		if (rstN && resValid) begin
			pulseCount++;
			if (expData.size() == 0) begin
				$display("ERROR: result pulse at %0t with no instruction outstanding", $time);
				errorCount++;
			end else begin
				wantDest = expDest.pop_front();
				wantData = expData.pop_front();
				if (resDest != wantDest || resData != wantData) begin
					$display("CHECK FAILED at %0t: dest %0d data %h, expected dest %0d data %h",
						$time, resDest, resData, wantDest, wantData);
					errorCount++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("ERROR: run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int                              errBase;
		int                              issBase;
		int                              pulseBase;
		int                              xferBase;
		logic [dspPkg::regAddrWidth-1:0] idx;
		logic [dspPkg::regAddrWidth-1:0] dest;
		logic [dspPkg::regAddrWidth-1:0] prev;
		for (int i = 0; i < dspPkg::regCount; i++) begin
			model[i] = '0;
		end
		rstN  <= 1'b0;
		req   <= 1'b0;
		instr <= '0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);

		errBase = errorCount + checkErrors;
		issBase = issuedCount;
		for (int i = 0; i < dspPkg::regCount; i++) begin
			idx = dspPkg::regAddrWidth'(i);
			sendInstr(makeInstr(dspPkg::opRead, idx, idx, idx, idx, '0));
		end
		finishTest("initial state", errBase, issBase);

		errBase = errorCount + checkErrors;
		issBase = issuedCount;
		for (int i = 0; i < dspPkg::regCount; i++) begin
			idx = dspPkg::regAddrWidth'(i);
			sendInstr(makeInstr(dspPkg::opLoad, idx, idx, idx, idx, randByte()));
			sendInstr(makeInstr(dspPkg::opRead, idx, idx, idx, idx, '0));
		end
		finishTest("loads", errBase, issBase);

		errBase = errorCount + checkErrors;
		issBase = issuedCount;
		repeat (200) begin
			sendInstr(makeInstr(randArith(), randReg(), randReg(), randReg(), randReg(), '0));
		end
		finishTest("arithmetic", errBase, issBase);

		// each instruction reads the register the previous one wrote.
		errBase = errorCount + checkErrors;
		issBase = issuedCount;
		prev = randReg();
		repeat (40) begin
			dest = randReg();
			sendInstr(makeInstr(randArith(), dest, prev, randReg(), prev, '0));
			prev = dest;
		end
		finishTest("dependence", errBase, issBase);

		errBase   = errorCount + checkErrors;
		issBase   = issuedCount;
		pulseBase = pulseCount;
		xferBase  = transferCount;
		repeat (50) begin
			repeat (randGap()) @(posedge clk);
			sendInstr(makeInstr(randAny(), randReg(), randReg(), randReg(), randReg(),
				randByte()));
		end
		waitDrain();
		repeat (20) @(posedge clk); // no late pulses allowed.
		if (pulseCount - pulseBase != transferCount - xferBase) begin
			$display("CHECK FAILED at %0t: %0d result pulses for %0d transfers", $time,
				pulseCount - pulseBase, transferCount - xferBase);
			checkErrors++;
		end
		finishTest("handshake", errBase, issBase);

		$display("%0d tests, %0d results, %0d errors", testCount, pulseCount,
			errorCount + checkErrors);
		if (errorCount + checkErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
dspPkg.sv
regFile.sv
instrCapture.sv
operandFetch.sv
executeStage.sv
macPipe.sv
macPipe_properties.sv
macPipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the macPipe testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module macPipe_tb \
	--Mdir obj_dir

./obj_dir/VmacPipe_tb | tee sim.log

grep -q "Simulation completed successfully" sim.log
echo "run passed"
